/* design/softmc_cfg.svh */
`ifndef SOFTMC_CFG_SVH
`define SOFTMC_CFG_SVH

// ************************************************************
// Storage sizing
// ************************************************************

// Instruction queue entries
`define SOFTMC_IQ_DEPTH 16

// Readback FIFO entries
`define SOFTMC_RB_DEPTH 8

// ************************************************************
// Word and field widths
// ************************************************************

`define SOFTMC_DATA_W 32
`define SOFTMC_BANK_W 3
`define SOFTMC_ADDR_W 15
`define SOFTMC_WAIT_W 10

`endif

/* design/softmc_pkg.sv */
`include "softmc_cfg.svh"

package softmc_pkg;

  // Instruction class, top nibble of every instruction word
  // Any code with bit 3 set is a DDR command
  typedef enum logic [3:0] {
    op_end    = 4'h0,
    op_busdir = 4'h1,
    op_wait   = 4'h4,
    op_ddr    = 4'h8
  } opcode_e;

  // Command bus word, 22 bits
  typedef struct packed {
    logic                      cs_n;
    logic                      ras_n;
    logic                      cas_n;
    logic                      we_n;
    logic [`SOFTMC_BANK_W-1:0] ba;
    logic [`SOFTMC_ADDR_W-1:0] addr;
  } ddr_cmd_t;

  // DDR view of an instruction
  typedef struct packed {
    opcode_e                   opcode;
    logic                      cs_n;
    logic                      ras_n;
    logic                      cas_n;
    logic                      we_n;
    logic [`SOFTMC_BANK_W-1:0] ba;
    logic [`SOFTMC_DATA_W-8-`SOFTMC_BANK_W-`SOFTMC_ADDR_W-1:0] rsvd;
    logic [`SOFTMC_ADDR_W-1:0] addr;
  } instr_ddr_t;

  // Control view, BUSDIR reads dir and WAIT reads count
  typedef struct packed {
    opcode_e                                    opcode;
    logic [`SOFTMC_DATA_W-5-`SOFTMC_WAIT_W-1:0] rsvd;
    logic                                       dir;
    logic [`SOFTMC_WAIT_W-1:0]                  count;
  } instr_ctl_t;

  typedef union packed {
    instr_ddr_t ddr;
    instr_ctl_t ctl;
  } instr_u;

  // Idle bus, chip deselected
  parameter ddr_cmd_t cmd_deselect = '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
                                       ba: '0, addr: '0};

endpackage

/* design/instr_queue.sv */
`timescale 1ns/1ps
`include "softmc_cfg.svh"

module instr_queue (
  input  logic               ddr3_ck_n_sdram,
  input  logic               arst_n,
  input  logic               app_en,
  input  softmc_pkg::instr_u app_instr,
  input  logic               iq_pop,
  input  logic               end_done,
  output logic               app_ack,
  output logic               iq_full,
  output logic               processing_iseq,
  output logic               iq_valid,
  output softmc_pkg::instr_u iq_head
);

  localparam int ptr_w = $clog2(`SOFTMC_IQ_DEPTH);
  localparam int cnt_w = $clog2(`SOFTMC_IQ_DEPTH + 1);
  localparam logic [ptr_w-1:0] last_idx = ptr_w'(`SOFTMC_IQ_DEPTH - 1);

  softmc_pkg::instr_u mem [`SOFTMC_IQ_DEPTH];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               accept;
  logic               accept_end;

  // Host may only write while idle and not full
  assign app_ack    = !iq_full && !processing_iseq;
  assign accept     = app_en && app_ack;
  assign accept_end = accept && (app_instr.ctl.opcode == softmc_pkg::op_end);

  assign iq_full  = (count == cnt_w'(`SOFTMC_IQ_DEPTH));
  assign iq_valid = processing_iseq && (count != '0);
  assign iq_head  = mem[rd_ptr];

  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (accept) begin
      mem[wr_ptr] <= app_instr;
    end
  end

  always_ff @(posedge ddr3_ck_n_sdram or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      processing_iseq <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
      end
      if (iq_pop) begin
        rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(accept) - cnt_w'(iq_pop);
      // END accepted starts playback, END popped stops it
      if (accept_end) begin
        processing_iseq <= 1'b1;
      end else if (end_done) begin
        processing_iseq <= 1'b0;
      end
    end
  end

  // Sequencer only pops an offered instruction
  assert property (@(posedge ddr3_ck_n_sdram) disable iff (!arst_n) iq_pop |-> iq_valid)
    else $error("instr_queue popped without a valid head");

  // Storage never overruns, a write never lands on an unread entry
  assert property (@(posedge ddr3_ck_n_sdram) disable iff (!arst_n)
    accept |-> ((count == '0) || (wr_ptr != rd_ptr)))
    else $error("instr_queue accepted an instruction while full");

endmodule

/* design/instr_sequencer.sv */
`timescale 1ns/1ps
`include "softmc_cfg.svh"

module instr_sequencer (
  input  logic                 ddr3_ck_n_sdram,
  input  logic                 arst_n,
  input  logic                 iq_valid,
  input  softmc_pkg::instr_u   iq_head,
  output logic                 iq_pop,
  output logic                 end_done,
  output softmc_pkg::ddr_cmd_t ddr_cmd,
  output logic                 rd_dir
);

  logic [3:0]                op;
  logic                      is_ddr;
  logic                      is_wait;
  logic                      is_busdir;
  logic                      is_end;
  logic                      ddr_pop;
  logic                      wait_pop;
  logic                      busdir_pop;
  logic [`SOFTMC_WAIT_W-1:0] wait_cnt;
  logic [`SOFTMC_WAIT_W-1:0] wait_load;

  // ************************************************************
  // Opcode decode
  // ************************************************************

  // Both views share the opcode nibble
  assign op        = iq_head.ctl.opcode;
  assign is_ddr    = |(op & softmc_pkg::op_ddr);
  assign is_wait   = !is_ddr && (op == softmc_pkg::op_wait);
  assign is_busdir = !is_ddr && (op == softmc_pkg::op_busdir);
  assign is_end    = !is_ddr && (op == softmc_pkg::op_end);

  // One pop per cycle and none while a WAIT runs
  assign iq_pop     = iq_valid && (wait_cnt == '0);
  assign ddr_pop    = iq_pop && is_ddr;
  assign wait_pop   = iq_pop && is_wait;
  assign busdir_pop = iq_pop && is_busdir;
  assign end_done   = iq_pop && is_end;

  // ************************************************************
  // Wait timer
  // ************************************************************

  // The WAIT pop cycle itself counts as the first idle cycle
  assign wait_load = (iq_head.ctl.count == '0) ? '0 : iq_head.ctl.count - 1'b1;

  always_ff @(posedge ddr3_ck_n_sdram or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
    end else if (wait_pop) begin
      wait_cnt <= wait_load;
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // ************************************************************
  // Command bus and data direction
  // ************************************************************

  always_ff @(posedge ddr3_ck_n_sdram or negedge arst_n) begin
    if (!arst_n) begin
      ddr_cmd <= softmc_pkg::cmd_deselect;
    end else if (ddr_pop) begin
      ddr_cmd <= '{cs_n:  iq_head.ddr.cs_n,
                   ras_n: iq_head.ddr.ras_n,
                   cas_n: iq_head.ddr.cas_n,
                   we_n:  iq_head.ddr.we_n,
                   ba:    iq_head.ddr.ba,
                   addr:  iq_head.ddr.addr};
    end else begin
      ddr_cmd <= softmc_pkg::cmd_deselect;
    end
  end

  // Read direction when dir is set
  always_ff @(posedge ddr3_ck_n_sdram or negedge arst_n) begin
    if (!arst_n) begin
      rd_dir <= 1'b0;
    end else if (busdir_pop) begin
      rd_dir <= iq_head.ctl.dir;
    end
  end

  // Bus stays idle unless the queue offered a DDR word one cycle before
  assert property (@(posedge ddr3_ck_n_sdram) disable iff (!arst_n)
    !(iq_valid && op[3]) |=> (ddr_cmd == softmc_pkg::cmd_deselect))
    else $error("ddr_cmd not deselect in a cycle without a DDR pop");

endmodule

/* design/rdback_fifo.sv */
`timescale 1ns/1ps
`include "softmc_cfg.svh"

module rdback_fifo (
  input  logic                      ddr3_ck_n_sdram,
  input  logic                      arst_n,
  input  logic                      rd_dir,
  input  logic [`SOFTMC_DATA_W-1:0] dq_in,
  input  logic                      dq_in_valid,
  input  logic                      rdback_fifo_rden,
  output logic [`SOFTMC_DATA_W-1:0] rdback_data,
  output logic                      rdback_fifo_empty
);

  localparam int ptr_w = $clog2(`SOFTMC_RB_DEPTH);
  localparam int cnt_w = $clog2(`SOFTMC_RB_DEPTH + 1);
  localparam logic [ptr_w-1:0] last_idx = ptr_w'(`SOFTMC_RB_DEPTH - 1);

  logic [`SOFTMC_DATA_W-1:0] mem [`SOFTMC_RB_DEPTH];
  logic [ptr_w-1:0]          wr_ptr;
  logic [ptr_w-1:0]          rd_ptr;
  logic [cnt_w-1:0]          count;
  logic                      full;
  logic                      push;
  logic                      pop;

  // Capture only in read direction, overflow words are lost
  assign full              = (count == cnt_w'(`SOFTMC_RB_DEPTH));
  assign rdback_fifo_empty = (count == '0);
  assign push              = dq_in_valid && rd_dir && !full;
  assign pop               = rdback_fifo_rden && !rdback_fifo_empty;

  // Show-ahead head word
  assign rdback_data = mem[rd_ptr];

  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (push) begin
      mem[wr_ptr] <= dq_in;
    end
  end

  always_ff @(posedge ddr3_ck_n_sdram or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // Head is real captured data whenever the host sees a word
  assert property (@(posedge ddr3_ck_n_sdram) disable iff (!arst_n)
    !rdback_fifo_empty |-> !$isunknown(rdback_data))
    else $error("rdback_data unknown while FIFO not empty");

endmodule

/* design/softmc_top.sv */
`timescale 1ns/1ps
`include "softmc_cfg.svh"

module softmc_top (
  input  logic                      ddr3_ck_n_sdram,
  input  logic                      arst_n,
  input  logic                      app_en,
  input  softmc_pkg::instr_u        app_instr,
  input  logic                      rdback_fifo_rden,
  input  logic [`SOFTMC_DATA_W-1:0] dq_in,
  input  logic                      dq_in_valid,
  output logic                      app_ack,
  output logic                      iq_full,
  output logic                      processing_iseq,
  output softmc_pkg::ddr_cmd_t      ddr_cmd,
  output logic [`SOFTMC_DATA_W-1:0] rdback_data,
  output logic                      rdback_fifo_empty
);

  // Queue to sequencer
  logic               iq_valid;
  logic               iq_pop;
  logic               end_done;
  softmc_pkg::instr_u iq_head;

  // Sequencer to readback path
  logic               rd_dir;

  instr_queue u_instr_queue (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .arst_n          (arst_n),
    .app_en          (app_en),
    .app_instr       (app_instr),
    .iq_pop          (iq_pop),
    .end_done        (end_done),
    .app_ack         (app_ack),
    .iq_full         (iq_full),
    .processing_iseq (processing_iseq),
    .iq_valid        (iq_valid),
    .iq_head         (iq_head)
  );

  instr_sequencer u_instr_sequencer (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .arst_n          (arst_n),
    .iq_valid        (iq_valid),
    .iq_head         (iq_head),
    .iq_pop          (iq_pop),
    .end_done        (end_done),
    .ddr_cmd         (ddr_cmd),
    .rd_dir          (rd_dir)
  );

  rdback_fifo u_rdback_fifo (
    .ddr3_ck_n_sdram   (ddr3_ck_n_sdram),
    .arst_n            (arst_n),
    .rd_dir            (rd_dir),
    .dq_in             (dq_in),
    .dq_in_valid       (dq_in_valid),
    .rdback_fifo_rden  (rdback_fifo_rden),
    .rdback_data       (rdback_data),
    .rdback_fifo_empty (rdback_fifo_empty)
  );

endmodule

/* bench/tb_softmc.sv */
`timescale 1ns/1ps
`include "softmc_cfg.svh"

module tb_softmc;

  localparam int timeout_cycles = 200;

  logic                      ddr3_ck_n_sdram;
  logic                      arst_n;
  logic                      app_en;
  softmc_pkg::instr_u        app_instr;
  logic                      rdback_fifo_rden;
  logic [`SOFTMC_DATA_W-1:0] dq_in;
  logic                      dq_in_valid;
  logic                      app_ack;
  logic                      iq_full;
  logic                      processing_iseq;
  softmc_pkg::ddr_cmd_t      ddr_cmd;
  logic [`SOFTMC_DATA_W-1:0] rdback_data;
  logic                      rdback_fifo_empty;

  int                        seed = 32'h2021_a8f8;
  int                        cycle_cnt = 0;
  softmc_pkg::ddr_cmd_t      cmd_log [$];
  int                        cyc_log [$];
  logic [`SOFTMC_DATA_W-1:0] rd_words [$];

  softmc_top dut (
    .ddr3_ck_n_sdram   (ddr3_ck_n_sdram),
    .arst_n            (arst_n),
    .app_en            (app_en),
    .app_instr         (app_instr),
    .rdback_fifo_rden  (rdback_fifo_rden),
    .dq_in             (dq_in),
    .dq_in_valid       (dq_in_valid),
    .app_ack           (app_ack),
    .iq_full           (iq_full),
    .processing_iseq   (processing_iseq),
    .ddr_cmd           (ddr_cmd),
    .rdback_data       (rdback_data),
    .rdback_fifo_empty (rdback_fifo_empty)
  );

  initial begin
    ddr3_ck_n_sdram = 1'b0;
    forever #4 ddr3_ck_n_sdram = ~ddr3_ck_n_sdram;
  end

  always @(posedge ddr3_ck_n_sdram) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ************************************************************
  // Helpers
  // ************************************************************

  task automatic stop_on_failure();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("[ERROR] %0t: %s", $time, msg);
      stop_on_failure();
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: %s", what);
    stop_on_failure();
  endtask

  function automatic softmc_pkg::ddr_cmd_t cmd_word(input logic cs_n, input logic ras_n,
      input logic cas_n, input logic we_n, input logic [`SOFTMC_BANK_W-1:0] ba,
      input logic [`SOFTMC_ADDR_W-1:0] addr);
    softmc_pkg::ddr_cmd_t c;
    c.cs_n  = cs_n;
    c.ras_n = ras_n;
    c.cas_n = cas_n;
    c.we_n  = we_n;
    c.ba    = ba;
    c.addr  = addr;
    return c;
  endfunction

  // DDR instruction carrying the same fields as the expected bus word
  function automatic softmc_pkg::instr_u ddr_instr(input softmc_pkg::ddr_cmd_t c);
    softmc_pkg::instr_u w;
    w            = '0;
    w.ddr.opcode = softmc_pkg::op_ddr;
    w.ddr.cs_n   = c.cs_n;
    w.ddr.ras_n  = c.ras_n;
    w.ddr.cas_n  = c.cas_n;
    w.ddr.we_n   = c.we_n;
    w.ddr.ba     = c.ba;
    w.ddr.addr   = c.addr;
    return w;
  endfunction

  function automatic softmc_pkg::instr_u ctl_instr(input softmc_pkg::opcode_e op,
      input logic dir, input logic [`SOFTMC_WAIT_W-1:0] count);
    softmc_pkg::instr_u w;
    w           = '0;
    w.ctl.opcode = op;
    w.ctl.dir    = dir;
    w.ctl.count  = count;
    return w;
  endfunction

  task automatic write_instr(input softmc_pkg::instr_u w);
    int n;
    n         = 0;
    app_en    = 1'b1;
    app_instr = w;
    while (!app_ack) begin
      @(negedge ddr3_ck_n_sdram);
      n++;
      if (n > timeout_cycles) timeout_abort("app_ack never rose for a host write");
    end
    // Accepted on the rising edge in between
    @(negedge ddr3_ck_n_sdram);
    app_en = 1'b0;
  endtask

  task automatic wait_sequence_done();
    int n;
    n = 0;
    while (processing_iseq || dq_in_valid) begin
      @(negedge ddr3_ck_n_sdram);
      n++;
      if (n > timeout_cycles) timeout_abort("instruction sequence did not finish");
    end
  endtask

  task automatic clear_logs();
    cmd_log.delete();
    cyc_log.delete();
  endtask

  // Command monitor, any cycle with chip select low
  always @(negedge ddr3_ck_n_sdram) begin
    if (arst_n && ddr_cmd.cs_n == 1'b0) begin
      cmd_log.push_back(ddr_cmd);
      cyc_log.push_back(cycle_cnt);
    end
  end

  // Memory model, a RD returns a burst of four words two cycles later
  initial begin : memory_responder
    logic [`SOFTMC_DATA_W-1:0] w;
    forever begin
      @(negedge ddr3_ck_n_sdram);
      if (arst_n && ddr_cmd == cmd_word(1'b0, 1'b1, 1'b0, 1'b1, ddr_cmd.ba, ddr_cmd.addr)) begin
        repeat (2) @(negedge ddr3_ck_n_sdram);
        for (int i = 0; i < 4; i++) begin
          w = $random(seed);
          rd_words.push_back(w);
          dq_in       = w;
          dq_in_valid = 1'b1;
          @(negedge ddr3_ck_n_sdram);
        end
        dq_in_valid = 1'b0;
      end
    end
  end

  // ************************************************************
  // Tests
  // ************************************************************

  task automatic test_reset_state();
    check(ddr_cmd == cmd_word(1'b1, 1'b1, 1'b1, 1'b1, 3'd0, 15'd0),
          $sformatf("ddr_cmd %h not deselect after reset", ddr_cmd));
    check(!processing_iseq, "processing_iseq high after reset");
    check(!iq_full, "iq_full high after reset");
    check(app_ack, "app_ack low after reset");
    check(rdback_fifo_empty, "rdback_fifo_empty low after reset");
  endtask

  task automatic test_cmd_sequence();
    softmc_pkg::ddr_cmd_t exp [3];
    exp[0] = cmd_word(1'b0, 1'b0, 1'b1, 1'b0, 3'd3, 15'd0);
    exp[1] = cmd_word(1'b0, 1'b0, 1'b1, 1'b1, 3'd3, 15'h00b2);
    exp[2] = cmd_word(1'b0, 1'b1, 1'b0, 1'b0, 3'd3, 15'h0008);
    clear_logs();
    write_instr(ddr_instr(exp[0]));
    write_instr(ctl_instr(softmc_pkg::op_wait, 1'b0, 10'd5));
    write_instr(ddr_instr(exp[1]));
    write_instr(ctl_instr(softmc_pkg::op_wait, 1'b0, 10'd6));
    write_instr(ddr_instr(exp[2]));
    write_instr(ctl_instr(softmc_pkg::op_end, 1'b0, 10'd0));
    check(processing_iseq, "processing_iseq low after END accepted");
    wait_sequence_done();
    check(cmd_log.size() == 3, $sformatf("saw %0d commands, expected 3", cmd_log.size()));
    for (int i = 0; i < 3; i++) begin
      check(cmd_log[i] == exp[i],
            $sformatf("command %0d is %h, expected %h", i, cmd_log[i], exp[i]));
    end
    check(cyc_log[1] - cyc_log[0] == 6, $sformatf("gap PRE to ACT %0d, expected 6",
          cyc_log[1] - cyc_log[0]));
    check(cyc_log[2] - cyc_log[1] == 7, $sformatf("gap ACT to WR %0d, expected 7",
          cyc_log[2] - cyc_log[1]));
  endtask

  task automatic test_ack_held_off();
    int                   n;
    int                   low_cycles;
    softmc_pkg::ddr_cmd_t exp;
    n          = 0;
    low_cycles = 0;
    exp        = cmd_word(1'b0, 1'b0, 1'b1, 1'b0, 3'd5, 15'd0);
    write_instr(ctl_instr(softmc_pkg::op_wait, 1'b0, 10'd20));
    write_instr(ctl_instr(softmc_pkg::op_end, 1'b0, 10'd0));
    // Host holds a PRE while the program runs
    app_en    = 1'b1;
    app_instr = ddr_instr(exp);
    while (!app_ack) begin
      check(processing_iseq, "app_ack low while not processing");
      low_cycles++;
      @(negedge ddr3_ck_n_sdram);
      n++;
      if (n > timeout_cycles) timeout_abort("app_ack stayed low after processing");
    end
    check(low_cycles > 0, "app_ack high during processing");
    check(!processing_iseq, "app_ack rose while processing_iseq high");
    @(negedge ddr3_ck_n_sdram);
    app_en = 1'b0;
    clear_logs();
    write_instr(ctl_instr(softmc_pkg::op_end, 1'b0, 10'd0));
    wait_sequence_done();
    check(cmd_log.size() == 1, $sformatf("saw %0d commands, expected 1", cmd_log.size()));
    check(cmd_log[0] == exp, $sformatf("held command %h, expected %h", cmd_log[0], exp));
  endtask

  task automatic test_queue_full();
    for (int i = 0; i < `SOFTMC_IQ_DEPTH - 1; i++) begin
      write_instr(ctl_instr(softmc_pkg::op_wait, 1'b0, 10'd1));
    end
    write_instr(ctl_instr(softmc_pkg::op_end, 1'b0, 10'd0));
    check(iq_full, "iq_full low with a full queue");
    check(!app_ack, "app_ack high with a full queue");
    wait_sequence_done();
    check(!iq_full, "iq_full high after execution");
    check(app_ack, "app_ack low after execution");
    write_instr(ctl_instr(softmc_pkg::op_end, 1'b0, 10'd0));
    wait_sequence_done();
  endtask

  task automatic run_read_program(input logic dir);
    write_instr(ctl_instr(softmc_pkg::op_busdir, dir, 10'd0));
    write_instr(ddr_instr(cmd_word(1'b0, 1'b0, 1'b1, 1'b1, 3'd1, 15'h0040)));
    write_instr(ddr_instr(cmd_word(1'b0, 1'b1, 1'b0, 1'b1, 3'd1, 15'h0010)));
    write_instr(ctl_instr(softmc_pkg::op_wait, 1'b0, 10'd10));
    write_instr(ctl_instr(softmc_pkg::op_end, 1'b0, 10'd0));
    wait_sequence_done();
    check(rd_words.size() == 4, $sformatf("responder sent %0d words", rd_words.size()));
  endtask

  task automatic test_readback();
    logic [`SOFTMC_DATA_W-1:0] exp;
    rd_words.delete();
    run_read_program(1'b1);
    for (int i = 0; i < 4; i++) begin
      exp = rd_words.pop_front();
      check(!rdback_fifo_empty, $sformatf("FIFO empty before word %0d", i));
      check(rdback_data == exp, $sformatf("readback word %0d is %h, expected %h", i,
            rdback_data, exp));
      rdback_fifo_rden = 1'b1;
      @(negedge ddr3_ck_n_sdram);
    end
    rdback_fifo_rden = 1'b0;
    check(rdback_fifo_empty, "FIFO not empty after draining four words");
  endtask

  task automatic test_write_dir_ignores_data();
    rd_words.delete();
    run_read_program(1'b0);
    check(rdback_fifo_empty, "read data captured in write direction");
    rd_words.delete();
  endtask

  initial begin
    arst_n           = 1'b0;
    app_en           = 1'b0;
    app_instr        = '0;
    rdback_fifo_rden = 1'b0;
    dq_in            = '0;
    dq_in_valid      = 1'b0;
    repeat (16) @(negedge ddr3_ck_n_sdram);
    arst_n = 1'b1;
    @(negedge ddr3_ck_n_sdram);
    test_reset_state();
    test_cmd_sequence();
    test_ack_held_off();
    test_queue_full();
    test_readback();
    test_write_dir_ignores_data();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* softmc_lite.f */
+incdir+design
design/softmc_pkg.sv
design/instr_queue.sv
design/instr_sequencer.sv
design/rdback_fifo.sv
design/softmc_top.sv
bench/tb_softmc.sv

/* Makefile */
# Verilator build and run of the softmc_lite testbench

TOP := tb_softmc

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -j 0 -f softmc_lite.f \
	  --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
